//--- source/nf_stream_pkg.sv
// ######################################
// nf_stream_pkg
// switch pipeline stream beat and the
// layout of its sideband (tuser) word
// ######################################

package nf_stream_pkg;

  // beat payload widths
  localparam int data_width = 64;
  localparam int keep_width = data_width / 8;

  // full pipeline sideband width
  localparam int tuser_width = 128;

  // one-hot interface code used in src_port / dst_port
  typedef logic [7:0] port_code_t;

  // host queue codes as seen by the pipeline
  localparam port_code_t port_qdma0 = 8'b0000_0010;
  localparam port_code_t port_qdma1 = 8'b0000_1000;

  // dst_port bit that selects each host queue
  localparam int dst_bit_qdma0 = 1;
  localparam int dst_bit_qdma1 = 3;

  // sideband sits in the low bits of the struct, in tuser order:
  // pkt_size [15:0], src_port [23:16], dst_port [31:24], rest reserved
  typedef struct packed {
    logic [data_width-1:0]    data;
    logic [keep_width-1:0]    keep;
    logic                     last;
    logic [tuser_width-33:0]  user_rsvd;
    port_code_t               dst_port;
    port_code_t               src_port;
    logic [15:0]              pkt_size;
  } nf_beat_t;

endpackage

//--- source/qdma_pkg.sv
// ######################################
// qdma_pkg
// host DMA queue stream beat, queue
// names and the one-hot queue code
// ######################################

package qdma_pkg;

  // queue beat, same data width as the pipeline
  typedef struct packed {
    logic [nf_stream_pkg::data_width-1:0] data;
    logic [nf_stream_pkg::keep_width-1:0] keep;
    logic                                 last;
    logic [15:0]                          size;
    logic [15:0]                          src;
    logic [15:0]                          dst;
  } qdma_beat_t;

  typedef enum logic {
    q0 = 1'b0,
    q1 = 1'b1
  } queue_t;

  // one-hot queue code carried in the c2h dst field
  function automatic logic [15:0] queue_dst_code(queue_t q);
    logic [15:0] code;
    case (q)
      q0:      code = 16'h0001;
      default: code = 16'h0002;
    endcase
    return code;
  endfunction

endpackage

//--- source/h2c_arbiter.sv
// ######################################
// h2c_arbiter
// shares the two h2c queues onto one
// stream, one whole packet per grant,
// alternating when both are waiting
// ######################################

module h2c_arbiter (
  input  logic                 axis_aclk,
  input  logic                 axis_rst,
  input  qdma_pkg::qdma_beat_t h2c_beat [2],
  input  logic [1:0]           h2c_valid,
  output logic [1:0]           h2c_ready,
  output qdma_pkg::qdma_beat_t grant_beat,
  output logic                 grant_valid,
  output qdma_pkg::queue_t     grant_queue,
  input  logic                 grant_ready
);

  typedef enum logic {
    idle,
    busy
  } state_t;

  state_t           state;
  qdma_pkg::queue_t held_queue;
  qdma_pkg::queue_t last_queue;
  qdma_pkg::queue_t pick;
  qdma_pkg::queue_t sel;
  logic             xfer;

  // candidate while idle, the queue not served last wins a tie
  always_comb begin
    if (h2c_valid[0] && h2c_valid[1]) begin
      if (last_queue == qdma_pkg::q0) begin
        pick = qdma_pkg::q1;
      end else begin
        pick = qdma_pkg::q0;
      end
    end else if (h2c_valid[1]) begin
      pick = qdma_pkg::q1;
    end else begin
      pick = qdma_pkg::q0;
    end
  end

  always_comb begin
    if (state == busy) begin
      sel = held_queue;
    end else begin
      sel = pick;
    end
  end

  // no register in the data path
  assign grant_queue  = sel;
  assign grant_beat   = h2c_beat[sel];
  assign grant_valid  = h2c_valid[sel];
  assign h2c_ready[0] = grant_ready && (sel == qdma_pkg::q0);
  assign h2c_ready[1] = grant_ready && (sel == qdma_pkg::q1);
  assign xfer         = grant_valid && grant_ready;

  // lock the grant as soon as a queue is presented, release after tlast
  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      state      <= idle;
      held_queue <= qdma_pkg::q0;
      last_queue <= qdma_pkg::q1;
    end else begin
      case (state)
        idle: begin
          if (grant_valid) begin
            held_queue <= pick;
            if (xfer && grant_beat.last) begin
              last_queue <= pick;
            end else begin
              state <= busy;
            end
          end
        end
        default: begin
          if (xfer && grant_beat.last) begin
            state      <= idle;
            last_queue <= held_queue;
          end
        end
      endcase
    end
  end

endmodule

//--- source/h2c_tagger.sv
// ######################################
// h2c_tagger
// registers a granted queue beat and
// builds the pipeline sideband for it
// ######################################

module h2c_tagger (
  input  logic                      axis_aclk,
  input  logic                      axis_rst,
  input  qdma_pkg::qdma_beat_t      grant_beat,
  input  logic                      grant_valid,
  input  qdma_pkg::queue_t          grant_queue,
  output logic                      grant_ready,
  output nf_stream_pkg::nf_beat_t   nf_rx_beat,
  output logic                      nf_rx_valid,
  input  logic                      nf_rx_ready
);

  logic                      first;
  logic                      load;
  nf_stream_pkg::port_code_t src_code;

  // take a beat when empty or when the held one leaves this edge
  assign grant_ready = !nf_rx_valid || nf_rx_ready;
  assign load        = grant_valid && grant_ready;

  assign src_code = (grant_queue == qdma_pkg::q0) ? nf_stream_pkg::port_qdma0
                                                   : nf_stream_pkg::port_qdma1;

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      nf_rx_valid <= 1'b0;
      first       <= 1'b1;
    end else begin
      if (load) begin
        nf_rx_valid <= 1'b1;
        first       <= grant_beat.last;
      end else if (nf_rx_ready) begin
        nf_rx_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (load) begin
      nf_rx_beat.data      <= grant_beat.data;
      nf_rx_beat.keep      <= grant_beat.keep;
      nf_rx_beat.last      <= grant_beat.last;
      nf_rx_beat.user_rsvd <= '0;
      nf_rx_beat.dst_port  <= '0;
      // later beats keep the sideband written on the first beat
      if (first) begin
        nf_rx_beat.pkt_size <= grant_beat.size;
        nf_rx_beat.src_port <= src_code;
      end
    end
  end

endmodule

//--- source/c2h_decoder.sv
// ######################################
// c2h_decoder
// decodes the queue mask from the first
// beat and holds it for the packet
// ######################################

module c2h_decoder (
  input  logic                    axis_aclk,
  input  logic                    axis_rst,
  input  nf_stream_pkg::nf_beat_t nf_tx_beat,
  input  logic                    nf_tx_valid,
  output logic                    nf_tx_ready,
  output nf_stream_pkg::nf_beat_t pkt_beat,
  output logic [1:0]              pkt_mask,
  output logic                    pkt_valid,
  input  logic                    pkt_ready
);

  typedef enum logic {
    first_beat,
    in_packet
  } state_t;

  state_t state;
  logic   load;

  assign nf_tx_ready = !pkt_valid || pkt_ready;
  assign load        = nf_tx_valid && nf_tx_ready;

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      state     <= first_beat;
      pkt_valid <= 1'b0;
    end else begin
      if (load) begin
        pkt_valid <= 1'b1;
        state     <= nf_tx_beat.last ? first_beat : in_packet;
      end else if (pkt_ready) begin
        pkt_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (load) begin
      pkt_beat.data      <= nf_tx_beat.data;
      pkt_beat.keep      <= nf_tx_beat.keep;
      pkt_beat.last      <= nf_tx_beat.last;
      pkt_beat.user_rsvd <= '0;
      // sideband and mask latched on the first beat only
      if (state == first_beat) begin
        pkt_beat.pkt_size <= nf_tx_beat.pkt_size;
        pkt_beat.src_port <= nf_tx_beat.src_port;
        pkt_beat.dst_port <= nf_tx_beat.dst_port;
        pkt_mask[0] <= nf_tx_beat.dst_port[nf_stream_pkg::dst_bit_qdma0];
        pkt_mask[1] <= nf_tx_beat.dst_port[nf_stream_pkg::dst_bit_qdma1];
      end
    end
  end

endmodule

//--- source/c2h_demux.sv
// ######################################
// c2h_demux
// routes or broadcasts each beat to the
// queue outputs named in its mask,
// empty mask beats are dropped
// ######################################

module c2h_demux (
  input  logic                    axis_aclk,
  input  logic                    axis_rst,
  input  nf_stream_pkg::nf_beat_t pkt_beat,
  input  logic [1:0]              pkt_mask,
  input  logic                    pkt_valid,
  output logic                    pkt_ready,
  output qdma_pkg::qdma_beat_t    c2h_beat [2],
  output logic [1:0]              c2h_valid,
  input  logic [1:0]              c2h_ready
);

  logic [1:0] can_take;
  logic       load;

  // a queue register can take a beat if empty or draining this edge
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      can_take[i] = !c2h_valid[i] || c2h_ready[i];
    end
  end

  // every selected queue must be free, unselected ones do not matter
  assign pkt_ready = &(can_take | ~pkt_mask);
  assign load      = pkt_valid && pkt_ready;

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      c2h_valid <= 2'b00;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (load && pkt_mask[i]) begin
          c2h_valid[i] <= 1'b1;
        end else if (c2h_ready[i]) begin
          c2h_valid[i] <= 1'b0;
        end
      end
    end
  end

  // one copy per selected queue, each with its own dst code
  always_ff @(posedge axis_aclk) begin
    for (int i = 0; i < 2; i++) begin
      if (load && pkt_mask[i]) begin
        c2h_beat[i].data <= pkt_beat.data;
        c2h_beat[i].keep <= pkt_beat.keep;
        c2h_beat[i].last <= pkt_beat.last;
        c2h_beat[i].size <= pkt_beat.pkt_size;
        c2h_beat[i].src  <= {8'h00, pkt_beat.src_port};
        c2h_beat[i].dst  <= qdma_pkg::queue_dst_code(qdma_pkg::queue_t'(i));
      end
    end
  end

endmodule

//--- source/dma_attach_top.sv
// ######################################
// dma_attach_top
// host DMA attachment: h2c queues into
// the pipeline, pipeline out to c2h
// ######################################

module dma_attach_top (
  input  logic                    axis_aclk,
  input  logic                    axis_rst,
  // host to card queues
  input  qdma_pkg::qdma_beat_t    h2c_beat [2],
  input  logic [1:0]              h2c_valid,
  output logic [1:0]              h2c_ready,
  // into the switch pipeline
  output nf_stream_pkg::nf_beat_t nf_rx_beat,
  output logic                    nf_rx_valid,
  input  logic                    nf_rx_ready,
  // out of the switch pipeline
  input  nf_stream_pkg::nf_beat_t nf_tx_beat,
  input  logic                    nf_tx_valid,
  output logic                    nf_tx_ready,
  // card to host queues
  output qdma_pkg::qdma_beat_t    c2h_beat [2],
  output logic [1:0]              c2h_valid,
  input  logic [1:0]              c2h_ready
);

  qdma_pkg::qdma_beat_t    grant_beat;
  logic                    grant_valid;
  qdma_pkg::queue_t        grant_queue;
  logic                    grant_ready;

  nf_stream_pkg::nf_beat_t pkt_beat;
  logic [1:0]              pkt_mask;
  logic                    pkt_valid;
  logic                    pkt_ready;

  h2c_arbiter u_h2c_arbiter (
    .axis_aclk   (axis_aclk),
    .axis_rst    (axis_rst),
    .h2c_beat    (h2c_beat),
    .h2c_valid   (h2c_valid),
    .h2c_ready   (h2c_ready),
    .grant_beat  (grant_beat),
    .grant_valid (grant_valid),
    .grant_queue (grant_queue),
    .grant_ready (grant_ready)
  );

  h2c_tagger u_h2c_tagger (
    .axis_aclk   (axis_aclk),
    .axis_rst    (axis_rst),
    .grant_beat  (grant_beat),
    .grant_valid (grant_valid),
    .grant_queue (grant_queue),
    .grant_ready (grant_ready),
    .nf_rx_beat  (nf_rx_beat),
    .nf_rx_valid (nf_rx_valid),
    .nf_rx_ready (nf_rx_ready)
  );

  c2h_decoder u_c2h_decoder (
    .axis_aclk   (axis_aclk),
    .axis_rst    (axis_rst),
    .nf_tx_beat  (nf_tx_beat),
    .nf_tx_valid (nf_tx_valid),
    .nf_tx_ready (nf_tx_ready),
    .pkt_beat    (pkt_beat),
    .pkt_mask    (pkt_mask),
    .pkt_valid   (pkt_valid),
    .pkt_ready   (pkt_ready)
  );

  c2h_demux u_c2h_demux (
    .axis_aclk   (axis_aclk),
    .axis_rst    (axis_rst),
    .pkt_beat    (pkt_beat),
    .pkt_mask    (pkt_mask),
    .pkt_valid   (pkt_valid),
    .pkt_ready   (pkt_ready),
    .c2h_beat    (c2h_beat),
    .c2h_valid   (c2h_valid),
    .c2h_ready   (c2h_ready)
  );

endmodule

//--- verif/tb_dma_attach.sv
// ######################################
// tb_dma_attach
// self-checking testbench for the host
// DMA attachment, both directions, with
// packets read from a stimulus file and
// random ready on every output
// ######################################

module tb_dma_attach;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int pkt_timeout = 300;
  localparam int run_limit   = 6000;

  logic                    axis_aclk = 1'b0;
  logic                    axis_rst;
  qdma_pkg::qdma_beat_t    h2c_beat [2];
  logic [1:0]              h2c_valid;
  logic [1:0]              h2c_ready;
  nf_stream_pkg::nf_beat_t nf_rx_beat;
  logic                    nf_rx_valid;
  logic                    nf_rx_ready;
  nf_stream_pkg::nf_beat_t nf_tx_beat;
  logic                    nf_tx_valid;
  logic                    nf_tx_ready;
  qdma_pkg::qdma_beat_t    c2h_beat [2];
  logic [1:0]              c2h_valid;
  logic [1:0]              c2h_ready;

  int seed;
  bit h2c_done;
  bit c2h_done;

  // beats to send and beats to expect with a length per list
  qdma_pkg::qdma_beat_t    h2c_src [2][64];
  int                      h2c_len [2];
  int                      h2c_pos [2];
  nf_stream_pkg::nf_beat_t rx_exp [2][64];
  int                      rx_len [2];
  int                      rx_pkts [2];
  nf_stream_pkg::nf_beat_t tx_src [128];
  int                      tx_len;
  int                      tx_pos;
  qdma_pkg::qdma_beat_t    c2h_exp [2][128];
  int                      c2h_len [2];

  // monitor state
  int rx_pos [2];
  int rx_seen [2];
  int rx_cur_q;
  int rx_prev_q;
  bit rx_in_pkt;
  int c2h_pos [2];

  dma_attach_top UUT (
    .axis_aclk   (axis_aclk),
    .axis_rst    (axis_rst),
    .h2c_beat    (h2c_beat),
    .h2c_valid   (h2c_valid),
    .h2c_ready   (h2c_ready),
    .nf_rx_beat  (nf_rx_beat),
    .nf_rx_valid (nf_rx_valid),
    .nf_rx_ready (nf_rx_ready),
    .nf_tx_beat  (nf_tx_beat),
    .nf_tx_valid (nf_tx_valid),
    .nf_tx_ready (nf_tx_ready),
    .c2h_beat    (c2h_beat),
    .c2h_valid   (c2h_valid),
    .c2h_ready   (c2h_ready)
  );

  always #50 axis_aclk = ~axis_aclk;

  task automatic abort_run(input string why);
    $display("=== FAIL ===");
    $fatal(1, why);
  endtask

  // keep of the last beat follows from the byte count
  function automatic logic [7:0] last_keep(input logic [15:0] size);
    int bytes;
    bytes = ((int'(size) - 1) % 8) + 1;
    return 8'((1 << bytes) - 1);
  endfunction

  task automatic read_records();
    int          fd;
    int          n;
    int          beats;
    int          q;
    string       line;
    logic [23:0] dir;
    logic [7:0]  sel;
    logic [7:0]  src;
    logic [7:0]  route;
    logic [15:0] size;
    logic [31:0] dseed;
    logic [63:0] data;
    logic [7:0]  keep;
    logic        last;
    fd = $fopen("verif/dma_attach_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file verif/dma_attach_stim.txt");
      abort_run("missing stimulus file");
    end
    h2c_len = '{0, 0};
    rx_len  = '{0, 0};
    rx_pkts = '{0, 0};
    c2h_len = '{0, 0};
    tx_len  = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 2 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %d %h %h %h", dir, sel, src, beats, size, dseed, route);
        if (n != 7) begin
          $display("stimulus line could not be read: %s", line);
          abort_run("bad stimulus line");
        end
        for (int b = 0; b < beats; b++) begin
          data = {dseed, dseed + 32'(b)};
          last = (b == beats - 1);
          keep = last ? last_keep(size) : 8'hff;
          if (dir == "h2c") begin
            q = int'(sel[0]);
            // junk size on later beats and a nonzero host dst that the sideband ignores
            h2c_src[q][h2c_len[q]] = '{data: data, keep: keep, last: last,
                                       size: (b == 0) ? size : ~size,
                                       src: {8'h00, src}, dst: {src, src}};
            h2c_len[q]++;
            rx_exp[q][rx_len[q]] = '{data: data, keep: keep, last: last, user_rsvd: '0,
                                     dst_port: 8'h00, src_port: route, pkt_size: size};
            rx_len[q]++;
          end else begin
            // later beats carry junk sideband so only the first beat counts
            tx_src[tx_len] = '{data: data, keep: keep, last: last, user_rsvd: '0,
                               dst_port: (b == 0) ? sel : ~sel,
                               src_port: (b == 0) ? src : ~src,
                               pkt_size: (b == 0) ? size : ~size};
            tx_len++;
            for (int i = 0; i < 2; i++) begin
              if (route[i]) begin
                c2h_exp[i][c2h_len[i]] = '{data: data, keep: keep, last: last, size: size,
                                           src: {8'h00, src},
                                           dst: (i == 0) ? 16'h0001 : 16'h0002};
                c2h_len[i]++;
              end
            end
          end
        end
        if (dir == "h2c") begin
          rx_pkts[int'(sel[0])]++;
        end
      end
    end
    $fclose(fd);
  endtask

  // both queue sources hold valid while they still have beats
  task automatic drive_h2c();
    int stall;
    stall = 0;
    while (h2c_pos[0] < h2c_len[0] || h2c_pos[1] < h2c_len[1]) begin
      @(negedge axis_aclk);
      for (int q = 0; q < 2; q++) begin
        h2c_valid[q] = h2c_pos[q] < h2c_len[q];
        if (h2c_valid[q]) begin
          h2c_beat[q] = h2c_src[q][h2c_pos[q]];
        end
      end
      @(posedge axis_aclk);
      stall++;
      for (int q = 0; q < 2; q++) begin
        if (h2c_valid[q] && h2c_ready[q]) begin
          if (h2c_src[q][h2c_pos[q]].last) begin
            stall = 0;
          end
          h2c_pos[q]++;
        end
      end
      if (stall > pkt_timeout) begin
        $display("timeout: an h2c packet was not taken within %0d cycles", pkt_timeout);
        abort_run("h2c timeout");
      end
    end
    @(negedge axis_aclk);
    h2c_valid = 2'b00;
    h2c_done  = 1'b1;
  endtask

  task automatic drive_c2h();
    int stall;
    stall = 0;
    while (tx_pos < tx_len) begin
      @(negedge axis_aclk);
      nf_tx_valid = 1'b1;
      nf_tx_beat  = tx_src[tx_pos];
      @(posedge axis_aclk);
      stall++;
      if (nf_tx_ready) begin
        if (tx_src[tx_pos].last) begin
          stall = 0;
        end
        tx_pos++;
      end
      if (stall > pkt_timeout) begin
        $display("timeout: a c2h packet was not taken within %0d cycles", pkt_timeout);
        abort_run("c2h timeout");
      end
    end
    @(negedge axis_aclk);
    nf_tx_valid = 1'b0;
    c2h_done    = 1'b1;
  endtask

  function automatic bit all_done();
    return h2c_done && c2h_done && rx_pos[0] == rx_len[0] && rx_pos[1] == rx_len[1]
           && c2h_pos[0] == c2h_len[0] && c2h_pos[1] == c2h_len[1];
  endfunction

  // ready on each output is high three cycles in four
  task automatic drive_ready_and_wait();
    int cycles;
    cycles = 0;
    while (!all_done()) begin
      @(negedge axis_aclk);
      nf_rx_ready  = ($random(seed) & 3) != 0;
      c2h_ready[0] = ($random(seed) & 3) != 0;
      c2h_ready[1] = ($random(seed) & 3) != 0;
      cycles++;
      if (cycles > run_limit) begin
        $display("timeout: traffic did not drain within %0d cycles", run_limit);
        abort_run("run timeout");
      end
    end
  endtask

  task automatic check_rx_beat(input nf_stream_pkg::nf_beat_t got);
    nf_stream_pkg::nf_beat_t want;
    int                      other;
    if (!rx_in_pkt) begin
      assert (got.src_port == 8'h02 || got.src_port == 8'h08) else begin
        $display("ERROR at %0t: nf_rx src_port %h is no host queue code", $time, got.src_port);
        abort_run("bad source port");
      end
      rx_cur_q = (got.src_port == 8'h08) ? 1 : 0;
      other    = 1 - rx_cur_q;
      // same queue twice only when the other one has nothing left
      assert (rx_prev_q != rx_cur_q || rx_seen[other] == rx_pkts[other]) else begin
        $display("ERROR at %0t: queue %0d served twice while queue %0d waits",
                 $time, rx_cur_q, other);
        abort_run("no alternation");
      end
      rx_seen[rx_cur_q]++;
      rx_in_pkt = 1'b1;
    end
    assert (rx_pos[rx_cur_q] < rx_len[rx_cur_q]) else begin
      $display("ERROR at %0t: extra nf_rx beat for queue %0d", $time, rx_cur_q);
      abort_run("extra beat");
    end
    want = rx_exp[rx_cur_q][rx_pos[rx_cur_q]];
    rx_pos[rx_cur_q]++;
    assert (got == want) else begin
      $display("ERROR at %0t: nf_rx queue %0d got %h %h %b size %h src %h dst %h",
               $time, rx_cur_q, got.data, got.keep, got.last, got.pkt_size,
               got.src_port, got.dst_port);
      $display("ERROR at %0t: nf_rx expected %h %h %b size %h src %h dst %h", $time,
               want.data, want.keep, want.last, want.pkt_size, want.src_port, want.dst_port);
      abort_run("nf_rx mismatch");
    end
    if (got.last) begin
      rx_in_pkt = 1'b0;
      rx_prev_q = rx_cur_q;
    end
  endtask

  task automatic check_c2h_beat(input int i, input qdma_pkg::qdma_beat_t got);
    qdma_pkg::qdma_beat_t want;
    assert (c2h_pos[i] < c2h_len[i]) else begin
      $display("ERROR at %0t: unexpected beat on c2h queue %0d", $time, i);
      abort_run("extra beat");
    end
    want = c2h_exp[i][c2h_pos[i]];
    c2h_pos[i]++;
    assert (got == want) else begin
      $display("ERROR at %0t: c2h queue %0d got %h %h %b size %h src %h dst %h", $time, i,
               got.data, got.keep, got.last, got.size, got.src, got.dst);
      $display("ERROR at %0t: c2h expected %h %h %b size %h src %h dst %h", $time,
               want.data, want.keep, want.last, want.size, want.src, want.dst);
      abort_run("c2h mismatch");
    end
  endtask

  // outputs sampled at the rising edge before the DUT registers update
  always @(posedge axis_aclk) begin
    if (axis_rst) begin
      rx_pos    = '{0, 0};
      rx_seen   = '{0, 0};
      c2h_pos   = '{0, 0};
      rx_in_pkt = 1'b0;
      rx_cur_q  = 0;
      rx_prev_q = -1;
    end else begin
      if (nf_rx_valid && nf_rx_ready) begin
        check_rx_beat(nf_rx_beat);
      end
      for (int i = 0; i < 2; i++) begin
        if (c2h_valid[i] && c2h_ready[i]) begin
          check_c2h_beat(i, c2h_beat[i]);
        end
      end
    end
  end

  initial begin
    seed        = 32'hb01c3ce5;
    axis_rst    = 1'b1;
    h2c_beat[0] = '0;
    h2c_beat[1] = '0;
    h2c_valid   = 2'b00;
    nf_rx_ready = 1'b0;
    nf_tx_beat  = '0;
    nf_tx_valid = 1'b0;
    c2h_ready   = 2'b00;
    h2c_done    = 1'b0;
    c2h_done    = 1'b0;
    h2c_pos     = '{0, 0};
    tx_pos      = 0;
    read_records();
    repeat (4) @(posedge axis_aclk);
    @(negedge axis_aclk);
    axis_rst = 1'b0;
    assert (!nf_rx_valid && c2h_valid == 2'b00) else begin
      $display("ERROR at %0t: valid high after reset, nf_rx %b c2h %b",
               $time, nf_rx_valid, c2h_valid);
      abort_run("valid after reset");
    end
    fork
      drive_h2c();
      drive_c2h();
      drive_ready_and_wait();
    join
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- verif/dma_attach_stim.txt
# dir  sel  src  beats  size  seed  expect   (sel, src, size, seed, expect in hex)
# h2c: sel is the queue 0 or 1, expect is the nf_rx src_port code
# c2h: sel is the dst_port byte, expect is the queue mask, bit 0 queue 0, bit 1 queue 1
h2c 0 11 1 0005 1000a001 02
h2c 1 22 2 000c 2000b002 08
h2c 0 33 3 0018 1000a003 02
h2c 1 44 1 0008 2000b004 08
h2c 0 55 4 001d 1000a005 02
h2c 1 66 3 0011 2000b006 08
h2c 0 77 2 0010 1000a007 02
h2c 1 88 2 000f 2000b008 08
h2c 1 99 1 0003 2000b009 08
h2c 1 aa 5 0027 2000b00a 08
c2h 02 02 2 000e 3000c001 1
c2h 08 08 3 0014 3000c002 2
c2h 0a 02 2 0010 3000c003 3
c2h 00 08 2 000b 3000c004 0
c2h 02 08 1 0006 3000c005 1
c2h 80 02 3 0017 3000c006 0
c2h 08 02 2 0009 3000c007 2
c2h 22 08 4 001f 3000c008 1
c2h 0a 08 1 0001 3000c009 3
c2h 88 02 2 0010 3000c00a 2
c2h 01 02 1 0004 3000c00b 0
c2h 0a 02 3 0013 3000c00c 3
c2h 08 08 1 0008 3000c00d 2

//--- files.f
source/nf_stream_pkg.sv
source/qdma_pkg.sv
source/h2c_arbiter.sv
source/h2c_tagger.sv
source/c2h_decoder.sv
source/c2h_demux.sv
source/dma_attach_top.sv
verif/tb_dma_attach.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the pass line shows up
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_dma_attach -f files.f -o sim_dma_attach

out="$(./obj_dir/sim_dma_attach || true)"
echo "$out"

if grep -qF "=== PASS ===" <<< "$out"; then
  exit 0
else
  exit 1
fi
